//--- tb.f
+incdir+.
mem_bus_pkg.sv
pc_ctrl_pkg.sv
fetch_if.sv
pc_sequencer.sv
fetch_port.sv
inst_predecode.sv
fetch_top.sv
fetch_sva.sv
fetch_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module fetch_tb -f tb.f -o fetch_sim \
    && ./obj_dir/fetch_sim | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && echo "simulation run ok" \
    || { echo "simulation run not ok"; exit 1; }

//--- fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_tb;

    localparam int PERIOD     = 100;
    localparam int NUM_ROWS   = 16;
    localparam int STALL_FROM = 9;                        // out_ready turns random here

    typedef struct packed {
        mem_bus_pkg::addr_t      pc;
        mem_bus_pkg::inst_t      inst;
        pc_ctrl_pkg::inst_kind_t kind;
        mem_bus_pkg::addr_t      target;   // jal target or resolved branch/jalr pc
        int                      delay;    // cycles before redirect or md_done
    } row_t;

    // program in execution order
    localparam row_t PROG [NUM_ROWS] = '{
        '{32'h8000_0000, 32'h0010_0093, pc_ctrl_pkg::KIND_ALU,    32'h0, 0},  // addi x1,x0,1
        '{32'h8000_0004, 32'h0000_a103, pc_ctrl_pkg::KIND_LOAD,   32'h0, 0},  // lw x2,0(x1)
        '{32'h8000_0008, 32'h0020_a223, pc_ctrl_pkg::KIND_STORE,  32'h0, 0},  // sw x2,4(x1)
        '{32'h8000_000c, 32'h0020_81b3, pc_ctrl_pkg::KIND_ALU,    32'h0, 0},  // add x3,x1,x2
        '{32'h8000_0010, 32'h0200_006f, pc_ctrl_pkg::KIND_JAL,    32'h8000_0030, 0},
        '{32'h8000_0030, 32'h0220_8233, pc_ctrl_pkg::KIND_MULDIV, 32'h0, 3},  // mul x4,x1,x2
        '{32'h8000_0034, 32'h0420_8663, pc_ctrl_pkg::KIND_BRANCH, 32'h8000_0080, 4},  // taken
        '{32'h8000_0080, 32'h0050_0293, pc_ctrl_pkg::KIND_ALU,    32'h0, 0},  // addi x5,x0,5
        '{32'h8000_0084, 32'h0000_8067, pc_ctrl_pkg::KIND_JALR,   32'h8000_0100, 2},
        '{32'h8000_0100, 32'h0000_0073, pc_ctrl_pkg::KIND_SYSTEM, 32'h0, 0},  // ecall
        '{32'h8000_0104, 32'hfbdf_f06f, pc_ctrl_pkg::KIND_JAL,    32'h8000_00c0, 0},  // back
        '{32'h8000_00c0, 32'h0211_4333, pc_ctrl_pkg::KIND_MULDIV, 32'h0, 0},  // div x6,x2,x1
        '{32'h8000_00c4, 32'h4011_03b3, pc_ctrl_pkg::KIND_ALU,    32'h0, 0},  // sub x7,x2,x1
        '{32'h8000_00c8, 32'h0000_9463, pc_ctrl_pkg::KIND_BRANCH, 32'h8000_00cc, 1},  // not taken
        '{32'h8000_00cc, 32'h1234_5437, pc_ctrl_pkg::KIND_ALU,    32'h0, 0},  // lui x8
        '{32'h8000_00d0, 32'h0080_a483, pc_ctrl_pkg::KIND_LOAD,   32'h0, 0}   // lw x9,8(x1)
    };

    logic                    clk;
    logic                    rst_n;
    logic                    ar_valid;
    logic                    ar_ready;
    mem_bus_pkg::addr_t      ar_addr;
    mem_bus_pkg::bus_id_t    ar_id;
    logic                    r_valid;
    mem_bus_pkg::inst_t      r_data;
    mem_bus_pkg::bus_id_t    r_id;
    logic                    redirect_valid;
    mem_bus_pkg::addr_t      redirect_pc;
    logic                    md_done;
    logic                    out_valid;
    logic                    out_ready;
    mem_bus_pkg::addr_t      out_pc;
    mem_bus_pkg::inst_t      out_inst;
    pc_ctrl_pkg::inst_kind_t out_kind;

    integer               seed = 66769;
    int                   cyc = 0;
    bit                   stall_on = 1'b0;
    bit                   seen_ar = 1'b0;
    mem_bus_pkg::addr_t   rsp_addr [$];   // reads accepted, answered in order
    mem_bus_pkg::bus_id_t rsp_id [$];
    int                   rsp_due [$];

    fetch_top fetch_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_ROWS * 200 * PERIOD);
        $display("watchdog expired, the output stalled before the program finished");
        $display("test failed");
        $fatal(1);
    end

    function automatic int find_row(mem_bus_pkg::addr_t pc);
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (PROG[i].pc == pc) return i;
        end
        return -1;
    endfunction

    // addi x0 outside the program, immediate folded from the whole address
    function automatic mem_bus_pkg::inst_t fill_word(mem_bus_pkg::addr_t addr);
        logic [11:0] imm;
        imm = addr[31:20] ^ addr[19:8] ^ {4'b0000, addr[7:0]};
        return {imm, 5'd0, 3'b000, 5'd0, 7'b0010011};
    endfunction

    function automatic mem_bus_pkg::inst_t mem_word(mem_bus_pkg::addr_t addr);
        int row;
        row = find_row(addr);
        return (row < 0) ? fill_word(addr) : PROG[row].inst;
    endfunction

    task automatic check_addr(string name, mem_bus_pkg::addr_t got, mem_bus_pkg::addr_t exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_inst(string name, mem_bus_pkg::inst_t got, mem_bus_pkg::inst_t exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_id(string name, mem_bus_pkg::bus_id_t got,
                            mem_bus_pkg::bus_id_t exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_kind(string name, pc_ctrl_pkg::inst_kind_t got,
                              pc_ctrl_pkg::inst_kind_t exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s = %s, expected %s", $time, name, got.name(),
                     exp.name());
            $display("test failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // one falling edge: memory model, ready lines, pulses back low
    task automatic drive_cycle;
        @(negedge clk);
        cyc++;
        redirect_valid = 1'b0;
        md_done        = 1'b0;
        r_valid        = 1'b0;
        if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
            r_valid = 1'b1;
            r_data  = mem_word(rsp_addr.pop_front());
            r_id    = rsp_id.pop_front();   // echo the tag
            rsp_due.delete(0);
        end
        ar_ready = ($unsigned($random(seed)) % 4) != 0;
        if (ar_valid && ar_ready) begin
            if (!seen_ar) begin
                check_addr("ar_addr", ar_addr, `RESET_PC);
                check_id("ar_id", ar_id, {`SRC_ID, {`EPOCH_W{1'b0}}});   // epoch 0 out of reset
            end
            seen_ar = 1'b1;
            rsp_addr.push_back(ar_addr);
            rsp_id.push_back(ar_id);
            rsp_due.push_back(cyc + 1 + int'($unsigned($random(seed)) % 4));
        end
        out_ready = stall_on ? (($unsigned($random(seed)) % 3) != 0) : 1'b1;
    endtask

    // core is parked, nothing may come out before the pulse
    task automatic wait_quiet(int cycles);
        repeat (cycles + 1) begin
            drive_cycle();
            check_flag("out_valid", out_valid, 1'b0);
        end
    endtask

    initial begin
        int                      row;
        mem_bus_pkg::addr_t      exp_pc;
        mem_bus_pkg::inst_t      exp_inst;
        pc_ctrl_pkg::inst_kind_t exp_kind;
        rst_n          = 1'b0;
        ar_ready       = 1'b0;
        r_valid        = 1'b0;
        r_data         = '0;
        r_id           = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        md_done        = 1'b0;
        out_ready      = 1'b0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("ar_valid", ar_valid, 1'b0);
        drive_cycle();
        check_flag("ar_valid", ar_valid, 1'b1);   // first clock out of reset

        exp_pc = `RESET_PC;
        for (int step = 0; step < NUM_ROWS; step++) begin
            stall_on = (step >= STALL_FROM);
            row      = find_row(exp_pc);
            exp_inst = mem_word(exp_pc);
            exp_kind = (row < 0) ? pc_ctrl_pkg::KIND_ALU : PROG[row].kind;
            do begin
                drive_cycle();
            end while (!(out_valid && out_ready));   // beat moves on the next rising edge
            check_addr("out_pc", out_pc, exp_pc);
            check_inst("out_inst", out_inst, exp_inst);
            check_kind("out_kind", out_kind, exp_kind);
            case (exp_kind)
                pc_ctrl_pkg::KIND_BRANCH, pc_ctrl_pkg::KIND_JALR: begin
                    wait_quiet(PROG[row].delay);
                    redirect_valid = 1'b1;
                    redirect_pc    = PROG[row].target;
                    exp_pc         = PROG[row].target;
                end
                pc_ctrl_pkg::KIND_MULDIV: begin
                    wait_quiet(PROG[row].delay);
                    md_done = 1'b1;
                    exp_pc  = exp_pc + 32'd4;
                end
                pc_ctrl_pkg::KIND_JAL: exp_pc = PROG[row].target;
                default:               exp_pc = exp_pc + 32'd4;
            endcase
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- fetch_sva.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_sva (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    ar_valid,
    input logic                    ar_ready,
    input mem_bus_pkg::addr_t      ar_addr,
    input mem_bus_pkg::bus_id_t    ar_id,
    input logic                    out_valid,
    input logic                    out_ready,
    input mem_bus_pkg::addr_t      out_pc,
    input mem_bus_pkg::inst_t      out_inst,
    input pc_ctrl_pkg::inst_kind_t out_kind,
    input logic                    redirect_valid,
    input logic                    md_done,
    input logic                    hold_valid,
    input pc_ctrl_pkg::inst_kind_t hold_kind
);

    logic wait_resolve;
    logic wait_md;

    // which resume pulse the sequencer is parked on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_resolve <= 1'b0;
            wait_md      <= 1'b0;
        end else if (hold_valid) begin
            wait_resolve <= (hold_kind != pc_ctrl_pkg::KIND_MULDIV);
            wait_md      <= (hold_kind == pc_ctrl_pkg::KIND_MULDIV);
        end else begin
            if (redirect_valid) wait_resolve <= 1'b0;
            if (md_done) wait_md <= 1'b0;
        end
    end

    ar_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_id))
        else $error("read request changed before ar_ready");

    out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=>
            out_valid && $stable(out_pc) && $stable(out_inst) && $stable(out_kind))
        else $error("output beat changed while stalled");

    redirect_a: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid |-> wait_resolve)
        else $error("redirect with no branch or jalr pending");

    md_done_a: assert property (@(posedge clk) disable iff (!rst_n)
        md_done |-> wait_md)
        else $error("md_done with no mul/div pending");

endmodule

bind fetch_top fetch_sva fetch_sva_inst (.*);

`default_nettype wire

//--- fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    ar_valid,
    input  logic                    ar_ready,
    output mem_bus_pkg::addr_t      ar_addr,
    output mem_bus_pkg::bus_id_t    ar_id,
    input  logic                    r_valid,
    input  mem_bus_pkg::inst_t      r_data,
    input  mem_bus_pkg::bus_id_t    r_id,
    input  logic                    redirect_valid,
    input  mem_bus_pkg::addr_t      redirect_pc,
    input  logic                    md_done,
    output logic                    out_valid,
    input  logic                    out_ready,
    output mem_bus_pkg::addr_t      out_pc,
    output mem_bus_pkg::inst_t      out_inst,
    output pc_ctrl_pkg::inst_kind_t out_kind
);

    fetch_if req_if ();
    fetch_if beat_if ();

    mem_bus_pkg::epoch_t     cur_epoch;
    logic                    jal_valid;
    mem_bus_pkg::addr_t      jal_target;
    logic                    hold_valid;
    pc_ctrl_pkg::inst_kind_t hold_kind;
    mem_bus_pkg::addr_t      hold_pc;

    pc_sequencer pc_sequencer_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .req            (req_if.src),
        .jal_valid      (jal_valid),
        .jal_target     (jal_target),
        .hold_valid     (hold_valid),
        .hold_kind      (hold_kind),
        .hold_pc        (hold_pc),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .md_done        (md_done),
        .cur_epoch      (cur_epoch)
    );

    fetch_port fetch_port_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req_if.dst),
        .beat      (beat_if.src),
        .cur_epoch (cur_epoch),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar_addr   (ar_addr),
        .ar_id     (ar_id),
        .r_valid   (r_valid),
        .r_data    (r_data),
        .r_id      (r_id)
    );

    inst_predecode inst_predecode_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat       (beat_if.dst),
        .cur_epoch  (cur_epoch),
        .jal_valid  (jal_valid),
        .jal_target (jal_target),
        .hold_valid (hold_valid),
        .hold_kind  (hold_kind),
        .hold_pc    (hold_pc),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_pc     (out_pc),
        .out_inst   (out_inst),
        .out_kind   (out_kind)
    );

endmodule

`default_nettype wire

//--- inst_predecode.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module inst_predecode (
    input  logic                    clk,
    input  logic                    rst_n,
    fetch_if.dst                    beat,
    input  mem_bus_pkg::epoch_t     cur_epoch,
    output logic                    jal_valid,
    output mem_bus_pkg::addr_t      jal_target,
    output logic                    hold_valid,
    output pc_ctrl_pkg::inst_kind_t hold_kind,
    output mem_bus_pkg::addr_t      hold_pc,
    output logic                    out_valid,
    input  logic                    out_ready,
    output mem_bus_pkg::addr_t      out_pc,
    output mem_bus_pkg::inst_t      out_inst,
    output pc_ctrl_pkg::inst_kind_t out_kind
);

    pc_ctrl_pkg::inst_kind_t kind;
    mem_bus_pkg::addr_t      j_imm;
    logic                    in_fresh;
    logic                    take;
    logic                    is_hold;
    logic                    is_trig;

    logic                    valid_q;
    mem_bus_pkg::epoch_t     epoch_q;
    logic                    trig_q;   // this entry caused the last flush

    always_comb begin
        case (beat.inst[6:0])
            7'b0110011: begin
                if (beat.inst[31:25] == 7'b0000001) begin
                    kind = pc_ctrl_pkg::KIND_MULDIV;   // M extension
                end else begin
                    kind = pc_ctrl_pkg::KIND_ALU;
                end
            end
            7'b0000011: kind = pc_ctrl_pkg::KIND_LOAD;
            7'b0100011: kind = pc_ctrl_pkg::KIND_STORE;
            7'b1100011: kind = pc_ctrl_pkg::KIND_BRANCH;
            7'b1101111: kind = pc_ctrl_pkg::KIND_JAL;
            7'b1100111: kind = pc_ctrl_pkg::KIND_JALR;
            7'b1110011: kind = pc_ctrl_pkg::KIND_SYSTEM;
            default:    kind = pc_ctrl_pkg::KIND_ALU;   // op-imm, lui, auipc, fence
        endcase
    end

    // J-type immediate, bit 0 always zero
    assign j_imm = {{(`XLEN - 20){beat.inst[31]}}, beat.inst[19:12], beat.inst[20],
                    beat.inst[30:21], 1'b0};

    assign in_fresh   = (beat.epoch == cur_epoch);
    assign beat.ready = !valid_q || out_ready;
    assign take       = beat.valid && beat.ready && in_fresh;

    assign is_hold = (kind == pc_ctrl_pkg::KIND_BRANCH) || (kind == pc_ctrl_pkg::KIND_JALR)
                     || (kind == pc_ctrl_pkg::KIND_MULDIV);
    assign is_trig = is_hold || (kind == pc_ctrl_pkg::KIND_JAL);

    // pulses go out as the word enters the output register
    assign jal_valid  = take && (kind == pc_ctrl_pkg::KIND_JAL);
    assign jal_target = beat.pc + j_imm;
    assign hold_valid = take && is_hold;
    assign hold_kind  = kind;
    assign hold_pc    = beat.pc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0;
        end else if (valid_q && (epoch_q != cur_epoch) && !trig_q) begin
            valid_q <= 1'b0;   // overtaken by a flush
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_pc   <= beat.pc;
            out_inst <= beat.inst;
            out_kind <= kind;
            epoch_q  <= beat.epoch;
            trig_q   <= is_trig;
        end
    end

    assign out_valid = valid_q;

endmodule

`default_nettype wire

//--- fetch_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_port (
    input  logic                 clk,
    input  logic                 rst_n,
    fetch_if.dst                 req,
    fetch_if.src                 beat,
    input  mem_bus_pkg::epoch_t  cur_epoch,
    output logic                 ar_valid,
    input  logic                 ar_ready,
    output mem_bus_pkg::addr_t   ar_addr,
    output mem_bus_pkg::bus_id_t ar_id,
    input  logic                 r_valid,
    input  mem_bus_pkg::inst_t   r_data,
    input  mem_bus_pkg::bus_id_t r_id
);

    localparam int DEPTH = `FETCH_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W:0] LIMIT = (CNT_W + 1)'(DEPTH);

    logic                rq_valid;
    mem_bus_pkg::addr_t  rq_pc;
    mem_bus_pkg::epoch_t rq_epoch;
    logic                ar_hs;
    logic                req_hs;
    logic [CNT_W-1:0]    out_cnt;   // reads issued, no response yet
    logic [CNT_W-1:0]    buf_cnt;
    logic [CNT_W:0]      used;

    mem_bus_pkg::addr_t  pcq_mem [DEPTH];
    logic [PTR_W-1:0]    pcq_wr;
    logic [PTR_W-1:0]    pcq_rd;

    mem_bus_pkg::addr_t  buf_pc    [DEPTH];
    mem_bus_pkg::inst_t  buf_inst  [DEPTH];
    mem_bus_pkg::epoch_t buf_epoch [DEPTH];
    logic [PTR_W-1:0]    buf_wr;
    logic [PTR_W-1:0]    buf_rd;

    mem_bus_pkg::epoch_t rsp_epoch;
    logic                rsp_keep;
    logic                head_stale;
    logic                buf_pop;

    assign ar_hs  = rq_valid && ar_ready;
    assign used   = {1'b0, out_cnt} + {1'b0, buf_cnt} + {{CNT_W{1'b0}}, rq_valid};
    // never more in flight than the buffer can take back
    assign req.ready = (used < LIMIT) && (!rq_valid || ar_ready);
    assign req_hs    = req.valid && req.ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rq_valid <= 1'b0;
        end else if (req_hs) begin
            rq_valid <= 1'b1;
        end else if (ar_hs) begin
            rq_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_hs) begin
            rq_pc    <= req.pc;
            rq_epoch <= req.epoch;
        end
    end

    assign ar_valid = rq_valid;
    assign ar_addr  = rq_pc;
    assign ar_id    = {`SRC_ID, rq_epoch};

    // pc of each outstanding read, responses come back in order
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            pcq_mem[pcq_wr] <= rq_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_cnt <= '0;
            pcq_wr  <= '0;
            pcq_rd  <= '0;
        end else begin
            case ({ar_hs, r_valid})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;
            endcase
            if (ar_hs) pcq_wr <= pcq_wr + 1'b1;
            if (r_valid) pcq_rd <= pcq_rd + 1'b1;
        end
    end

    assign rsp_epoch = r_id[`EPOCH_W-1:0];
    assign rsp_keep  = r_valid && (r_id[`ID_W-1:`EPOCH_W] == `SRC_ID)
                       && (rsp_epoch == cur_epoch);

    always_ff @(posedge clk) begin
        if (rsp_keep) begin
            buf_pc[buf_wr]    <= pcq_mem[pcq_rd];
            buf_inst[buf_wr]  <= r_data;
            buf_epoch[buf_wr] <= rsp_epoch;
        end
    end

    // flow changed after the entry went in
    assign head_stale = (buf_cnt != '0) && (buf_epoch[buf_rd] != cur_epoch);
    assign beat.valid = (buf_cnt != '0) && !head_stale;
    assign beat.pc    = buf_pc[buf_rd];
    assign beat.inst  = buf_inst[buf_rd];
    assign beat.epoch = buf_epoch[buf_rd];
    assign buf_pop    = (beat.valid && beat.ready) || head_stale;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_cnt <= '0;
            buf_wr  <= '0;
            buf_rd  <= '0;
        end else begin
            case ({rsp_keep, buf_pop})
                2'b10:   buf_cnt <= buf_cnt + 1'b1;
                2'b01:   buf_cnt <= buf_cnt - 1'b1;
                default: buf_cnt <= buf_cnt;
            endcase
            if (rsp_keep) buf_wr <= buf_wr + 1'b1;
            if (buf_pop) buf_rd <= buf_rd + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetch_settings.svh"

module pc_sequencer (
    input  logic                    clk,
    input  logic                    rst_n,
    fetch_if.src                    req,
    input  logic                    jal_valid,
    input  mem_bus_pkg::addr_t      jal_target,
    input  logic                    hold_valid,
    input  pc_ctrl_pkg::inst_kind_t hold_kind,
    input  mem_bus_pkg::addr_t      hold_pc,
    input  logic                    redirect_valid,
    input  mem_bus_pkg::addr_t      redirect_pc,
    input  logic                    md_done,
    output mem_bus_pkg::epoch_t     cur_epoch
);

    localparam mem_bus_pkg::addr_t STEP = 'd4;

    pc_ctrl_pkg::pc_state_t state_q;
    pc_ctrl_pkg::pc_state_t state_d;
    mem_bus_pkg::addr_t     pc_q;
    mem_bus_pkg::addr_t     pc_d;
    mem_bus_pkg::epoch_t    epoch_q;
    logic                   bump;
    logic                   req_hs;

    assign req_hs = req.valid && req.ready;

    // next pc: jal first, then hold/resume, then sequential
    always_comb begin
        state_d = state_q;
        pc_d    = pc_q;
        bump    = 1'b0;
        if (jal_valid) begin
            pc_d = jal_target;
            bump = 1'b1;
        end else if (hold_valid) begin
            // park the fall-through pc, used again after md_done
            pc_d = hold_pc + STEP;
            bump = 1'b1;
            if (hold_kind == pc_ctrl_pkg::KIND_MULDIV) begin
                state_d = pc_ctrl_pkg::PC_HOLD_MD;
            end else begin
                state_d = pc_ctrl_pkg::PC_HOLD_RESOLVE;
            end
        end else begin
            case (state_q)
                pc_ctrl_pkg::PC_HOLD_RESOLVE: begin
                    if (redirect_valid) begin
                        pc_d    = redirect_pc;
                        state_d = pc_ctrl_pkg::PC_RUN;
                    end
                end
                pc_ctrl_pkg::PC_HOLD_MD: begin
                    if (md_done) begin
                        state_d = pc_ctrl_pkg::PC_RUN;   // pc already hold_pc+4
                    end
                end
                default: begin
                    if (req_hs) begin
                        pc_d = pc_q + STEP;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= pc_ctrl_pkg::PC_RUN;
            pc_q    <= `RESET_PC;
            epoch_q <= '0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
            if (bump) begin
                epoch_q <= epoch_q + 1'b1;   // kills everything younger
            end
        end
    end

    // offer a fetch every cycle while running
    assign req.valid = (state_q == pc_ctrl_pkg::PC_RUN);
    assign req.pc    = pc_q;
    assign req.inst  = '0;
    assign req.epoch = epoch_q;

    assign cur_epoch = epoch_q;

endmodule

`default_nettype wire

//--- fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

// one valid/ready beat between fetch stages
interface fetch_if;

    logic                valid;
    logic                ready;
    mem_bus_pkg::addr_t  pc;
    mem_bus_pkg::inst_t  inst;    // zero on the request side
    mem_bus_pkg::epoch_t epoch;

    modport src (
        output valid,
        output pc,
        output inst,
        output epoch,
        input  ready
    );

    modport dst (
        input  valid,
        input  pc,
        input  inst,
        input  epoch,
        output ready
    );

endinterface

`default_nettype wire

//--- pc_ctrl_pkg.sv
`default_nettype none

package pc_ctrl_pkg;

    // coarse class, enough to steer the pc
    typedef enum logic [2:0] {
        KIND_ALU,
        KIND_LOAD,
        KIND_STORE,
        KIND_BRANCH,
        KIND_JAL,
        KIND_JALR,
        KIND_MULDIV,
        KIND_SYSTEM
    } inst_kind_t;

    // sequencer issue state
    typedef enum logic [1:0] {
        PC_RUN,
        PC_HOLD_RESOLVE,   // waiting on branch/jalr outcome
        PC_HOLD_MD         // waiting on mul/div
    } pc_state_t;

endpackage

`default_nettype wire

//--- mem_bus_pkg.sv
`default_nettype none

`include "fetch_settings.svh"

package mem_bus_pkg;

    // byte address
    typedef logic [`XLEN-1:0] addr_t;

    // raw instruction word from memory
    typedef logic [`XLEN-1:0] inst_t;

    // tag on every read, src bits on top, epoch below
    typedef logic [`ID_W-1:0] bus_id_t;

    // flush generation
    typedef logic [`EPOCH_W-1:0] epoch_t;

endpackage

`default_nettype wire

//--- fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// datapath width, address and instruction
`define XLEN 32

`define RESET_PC 32'h8000_0000

// reads in flight, also response buffer depth (power of two)
`define FETCH_DEPTH 4

`define EPOCH_W 2

// read id = {SRC_ID, epoch}
`define ID_W 4
`define SRC_ID 2'b01

`endif
